/* blas_engine.f */
+incdir+hw
hw/blas_pkg.sv
hw/sync_fifo.sv
hw/issue_unit.sv
hw/tpu.sv
hw/commit_agg.sv
hw/blas_engine.sv
tb/blas_engine_asserts.sv
tb/tb_blas_engine.sv

/* hw/blas_engine.sv */
/*
 * BLAS issue engine top level
 * Issue unit broadcasting to NUM_TPU units, with in-order commit
 */

`timescale 1ns/1ns
`default_nettype none

`include "blas_macros.svh"

module blas_engine (
	input	wire						clock,
	input	wire						rst_n,
	input	wire						req,
	input	wire blas_pkg::opcode_t		opcode,
	input	wire blas_pkg::data_t		operand,
	input	wire blas_pkg::tpu_mask_t	tpu_en,
	output	wire						wait_issue,
	output	wire						commit,
	output	wire blas_pkg::issue_no_t	commit_no,
	output	wire blas_pkg::data_t		acc [`NUM_TPU-1:0]
);

	wire						issue;
	wire blas_pkg::issue_no_t	issue_no;
	wire blas_pkg::opcode_t		issue_op;
	wire blas_pkg::data_t		issue_operand;
	wire blas_pkg::tpu_mask_t	issue_mask;
	wire blas_pkg::tpu_mask_t	tpu_full;
	wire blas_pkg::tpu_mask_t	tpu_done;
	wire						rec_full;

	issue_unit issue_i (
		.clock			(clock),
		.rst_n			(rst_n),
		.req			(req),
		.opcode			(opcode),
		.operand		(operand),
		.tpu_en			(tpu_en),
		.tpu_full		(tpu_full),
		.rec_full		(rec_full),
		.wait_issue		(wait_issue),
		.issue			(issue),
		.issue_no		(issue_no),
		.issue_op		(issue_op),
		.issue_operand	(issue_operand),
		.issue_mask		(issue_mask)
	);

	//////////////////////////////////////////////////
	// Unit array, one mask bit each
	//////////////////////////////////////////////////
	for (genvar i = 0; i < `NUM_TPU; i++) begin : g_tpu
		tpu tpu_i (
			.clock			(clock),
			.rst_n			(rst_n),
			.issue			(issue),
			.issue_en		(issue_mask[i]),
			.issue_no		(issue_no),
			.issue_op		(issue_op),
			.issue_operand	(issue_operand),
			.full			(tpu_full[i]),
			.done			(tpu_done[i]),
			.acc			(acc[i])
		);
	end

	commit_agg commit_i (
		.clock			(clock),
		.rst_n			(rst_n),
		.issue			(issue),
		.issue_no		(issue_no),
		.issue_mask		(issue_mask),
		.done			(tpu_done),
		.rec_full		(rec_full),
		.commit			(commit),
		.commit_no		(commit_no)
	);

endmodule

`default_nettype wire

/* hw/blas_macros.svh */
/*
 * BLAS issue engine sizes
 * Unit count, datapath widths, queue depths and MUL latency
 */

`ifndef BLAS_MACROS_SVH
`define BLAS_MACROS_SVH

`define NUM_TPU		4		// Thread processing units
`define DATA_W		16		// Accumulator and operand width
`define ISSUE_W		4		// Issue numbers wrap modulo 16
`define QUEUE_DEPTH	4		// Per-unit instruction queue
`define REC_DEPTH	8		// Kept below 16 so numbers in flight stay unique
`define MUL_LAT		3		// Cycles a MUL occupies a unit

`endif

/* hw/blas_pkg.sv */
/*
 * BLAS issue engine types
 * Opcodes, data and issue numbers, unit masks and the two queue payloads
 */

`default_nettype none

`include "blas_macros.svh"

package blas_pkg;

	typedef enum logic [1:0] {
		CLR = 2'd0,		// Accumulator to zero
		ADD = 2'd1,		// Accumulator plus operand
		MUL = 2'd2		// Low half of accumulator times operand
	} opcode_t;

	typedef logic [`DATA_W-1:0]		data_t;
	typedef logic [`ISSUE_W-1:0]	issue_no_t;
	typedef logic [`NUM_TPU-1:0]	tpu_mask_t;

	// Unit queue entry
	typedef struct packed {
		opcode_t	op;
		data_t		operand;
		issue_no_t	no;
	} instr_t;

	// One outstanding issue, waiting for its enabled units
	typedef struct packed {
		issue_no_t	no;
		tpu_mask_t	mask;
	} commit_rec_t;

endpackage

`default_nettype wire

/* hw/commit_agg.sv */
/*
 * Commit aggregator
 * Retires issue numbers in order once every enabled unit has finished them
 */

`timescale 1ns/1ns
`default_nettype none

`include "blas_macros.svh"

module commit_agg (
	input	wire						clock,
	input	wire						rst_n,
	input	wire						issue,
	input	wire blas_pkg::issue_no_t	issue_no,
	input	wire blas_pkg::tpu_mask_t	issue_mask,
	input	wire blas_pkg::tpu_mask_t	done,
	output	logic						rec_full,
	output	logic						commit,
	output	blas_pkg::issue_no_t		commit_no
);

	localparam int CNT_W = $clog2(`REC_DEPTH + 2);

	blas_pkg::commit_rec_t	push_rec;
	blas_pkg::commit_rec_t	head;
	blas_pkg::tpu_mask_t	avail;
	logic					rec_empty;
	logic					bypass;
	logic					push;
	logic					retire;
	logic [CNT_W-1:0]		pend [`NUM_TPU];		// Completions not yet retired

	// Empty mask with nothing ahead of it commits straight away
	assign bypass	= issue && rec_empty && (issue_mask == '0);
	assign push		= issue && !bypass;
	assign push_rec	= '{no: issue_no, mask: issue_mask};

	sync_fifo #(
		.T		(blas_pkg::commit_rec_t),
		.DEPTH	(`REC_DEPTH)
	) rec_i (
		.clock		(clock),
		.rst_n		(rst_n),
		.push		(push),
		.push_data	(push_rec),
		.pop		(retire),
		.pop_data	(head),
		.empty		(rec_empty),
		.full		(rec_full)
	);

	always_comb begin
		for (int i = 0; i < `NUM_TPU; i++)
			avail[i] = (pend[i] != '0) || done[i];
	end

	assign retire = !rec_empty && ((avail & head.mask) == head.mask);

	//////////////////////////////////////////////////
	// Pending counters and commit pulse
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_TPU; i++)
				pend[i] <= '0;
			commit <= 1'b0;
		end else begin
			for (int i = 0; i < `NUM_TPU; i++)
				pend[i] <= pend[i] + CNT_W'(done[i]) - CNT_W'(retire && head.mask[i]);
			commit <= retire || bypass;
		end
	end

	always_ff @(posedge clock) begin
		if (retire || bypass)
			commit_no <= bypass ? issue_no : head.no;
	end

endmodule

`default_nettype wire

/* hw/issue_unit.sv */
/*
 * Issue unit
 * Numbers accepted requests and broadcasts them with their unit mask;
 * holds off new requests while any queue is full
 */

`timescale 1ns/1ns
`default_nettype none

module issue_unit (
	input	wire						clock,
	input	wire						rst_n,
	input	wire						req,
	input	wire blas_pkg::opcode_t		opcode,
	input	wire blas_pkg::data_t		operand,
	input	wire blas_pkg::tpu_mask_t	tpu_en,
	input	wire blas_pkg::tpu_mask_t	tpu_full,
	input	wire						rec_full,
	output	logic						wait_issue,
	output	logic						issue,
	output	blas_pkg::issue_no_t		issue_no,
	output	blas_pkg::opcode_t			issue_op,
	output	blas_pkg::data_t			issue_operand,
	output	blas_pkg::tpu_mask_t		issue_mask
);

	logic					accept;
	blas_pkg::issue_no_t	next_no;

	assign wait_issue	= rec_full || (|tpu_full);
	assign accept		= req && !wait_issue;		// Dropped requests take no number

	//////////////////////////////////////////////////
	// Issue strobe and number counter
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			issue	<= 1'b0;
			next_no	<= '0;
		end else begin
			issue <= accept;
			if (accept)
				next_no <= next_no + 1'b1;		// Wraps modulo 16
		end
	end

	// Broadcast payload
	always_ff @(posedge clock) begin
		if (accept) begin
			issue_no		<= next_no;
			issue_op		<= opcode;
			issue_operand	<= operand;
			issue_mask		<= tpu_en;
		end
	end

endmodule

`default_nettype wire

/* hw/sync_fifo.sv */
/*
 * Synchronous FIFO as a circular buffer with a type parameter for the payload
 * Full also counts a push arriving this cycle
 */

`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
	parameter type	T		= logic [7:0],
	parameter int	DEPTH	= 4
) (
	input	wire		clock,
	input	wire		rst_n,
	input	wire		push,
	input	wire T		push_data,
	input	wire		pop,
	output	T			pop_data,
	output	logic		empty,
	output	logic		full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T					mem [DEPTH];
	logic [PTR_W-1:0]	rd_ptr;
	logic [PTR_W-1:0]	wr_ptr;
	logic [CNT_W-1:0]	count;
	logic				do_push;
	logic				do_pop;

	assign do_push	= push && (count != CNT_W'(DEPTH));
	assign do_pop	= pop && !empty;
	assign empty	= (count == '0);
	// Writer sits one register behind its full check
	assign full		= (count == CNT_W'(DEPTH)) || (push && count == CNT_W'(DEPTH - 1));
	assign pop_data	= mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rd_ptr	<= '0;
			wr_ptr	<= '0;
			count	<= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

endmodule

`default_nettype wire

/* hw/tpu.sv */
/*
 * Thread processing unit
 * Queues broadcast instructions and runs them in order on a private accumulator
 * CLR and ADD take one cycle and MUL takes several
 */

`timescale 1ns/1ns
`default_nettype none

`include "blas_macros.svh"

module tpu (
	input	wire						clock,
	input	wire						rst_n,
	input	wire						issue,
	input	wire						issue_en,
	input	wire blas_pkg::issue_no_t	issue_no,
	input	wire blas_pkg::opcode_t		issue_op,
	input	wire blas_pkg::data_t		issue_operand,
	output	logic						full,
	output	logic						done,
	output	blas_pkg::data_t			acc
);

	localparam int CNT_W = $clog2(`MUL_LAT + 1);

	blas_pkg::instr_t	push_instr;
	blas_pkg::instr_t	head;
	blas_pkg::instr_t	cur;
	logic				push;
	logic				pop;
	logic				empty;
	logic				busy;
	logic [CNT_W-1:0]	cnt;

	function automatic blas_pkg::data_t alu(input blas_pkg::data_t a, input blas_pkg::instr_t i);
		case (i.op)
			blas_pkg::CLR:	alu = '0;
			blas_pkg::ADD:	alu = a + i.operand;
			blas_pkg::MUL:	alu = a * i.operand;		// Low DATA_W bits kept
			default:		alu = a;
		endcase
	endfunction

	assign push			= issue && issue_en;		// Own mask bit only
	assign push_instr	= '{op: issue_op, operand: issue_operand, no: issue_no};
	assign pop			= !busy && !empty;

	sync_fifo #(
		.T		(blas_pkg::instr_t),
		.DEPTH	(`QUEUE_DEPTH)
	) queue_i (
		.clock		(clock),
		.rst_n		(rst_n),
		.push		(push),
		.push_data	(push_instr),
		.pop		(pop),
		.pop_data	(head),
		.empty		(empty),
		.full		(full)
	);

	//////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			busy	<= 1'b0;
			cnt		<= '0;
			done	<= 1'b0;
			acc		<= '0;
		end else begin
			done <= 1'b0;
			if (pop) begin
				if (head.op == blas_pkg::MUL) begin
					busy	<= 1'b1;
					cnt		<= CNT_W'(`MUL_LAT - 1);
				end else begin
					acc		<= alu(acc, head);		// Single-cycle ops finish at pop
					done	<= 1'b1;
				end
			end else if (busy) begin
				if (cnt == CNT_W'(1)) begin
					acc		<= alu(acc, cur);
					done	<= 1'b1;
					busy	<= 1'b0;
				end
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pop)
			cur <= head;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the BLAS engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f blas_engine.f \
	--top-module tb_blas_engine -o sim_tb
./obj_dir/sim_tb +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
grep -q "SIMULATION PASSED" sim.log

/* tb/blas_engine_asserts.sv */
/*
 * Concurrent checks on the BLAS issue engine
 * Reset state, commit order, dropped requests and idle latency
 */

`timescale 1ns/1ns
`default_nettype none

`include "blas_macros.svh"

module blas_engine_asserts (
	input	wire						clock,
	input	wire						rst_n,
	input	wire						req,
	input	wire blas_pkg::opcode_t		opcode,
	input	wire blas_pkg::tpu_mask_t	tpu_en,
	input	wire						wait_issue,
	input	wire						commit,
	input	wire blas_pkg::issue_no_t	commit_no,
	input	wire blas_pkg::data_t		acc [`NUM_TPU-1:0],
	input	wire						issue,
	input	wire blas_pkg::tpu_mask_t	issue_mask,
	input	wire blas_pkg::tpu_mask_t	tpu_done
);

	logic					accepted;
	logic					idle;
	logic					add_start;
	logic					mul_start;
	logic					started;
	logic					acc_nz;
	logic					unit_over;
	logic [7:0]				outstanding;		// Accepted but not yet committed
	logic [3:0]				in_unit [`NUM_TPU];		// Sent to a unit, done not yet seen
	blas_pkg::issue_no_t	expect_no;
	logic					bad_reset		= 1'b0;
	logic					bad_order		= 1'b0;
	logic					bad_drop		= 1'b0;
	logic					bad_overflow	= 1'b0;
	logic					bad_latency		= 1'b0;
	logic					any_fail;

	assign accepted		= req && !wait_issue;
	assign idle			= (outstanding == '0);
	assign add_start	= rst_n && accepted && idle && opcode == blas_pkg::ADD && tpu_en != '0;
	assign mul_start	= rst_n && accepted && idle && opcode == blas_pkg::MUL && tpu_en != '0;
	assign any_fail		= bad_reset | bad_order | bad_drop | bad_overflow | bad_latency;

	always_comb begin
		acc_nz		= 1'b0;
		unit_over	= 1'b0;
		for (int i = 0; i < `NUM_TPU; i++) begin
			acc_nz		= acc_nz | (acc[i] != '0);
			// Full queue plus one instruction in execution
			unit_over	= unit_over | (in_unit[i] > 4'(`QUEUE_DEPTH + 1));
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			started		<= 1'b0;
			outstanding	<= '0;
			expect_no	<= '0;
			for (int i = 0; i < `NUM_TPU; i++)
				in_unit[i] <= '0;
		end else begin
			if (accepted)
				started <= 1'b1;
			outstanding <= outstanding + 8'(accepted) - 8'(commit);
			if (commit)
				expect_no <= expect_no + 1'b1;		// Wraps like the issue counter
			for (int i = 0; i < `NUM_TPU; i++)
				in_unit[i] <= in_unit[i] + 4'(issue && issue_mask[i]) - 4'(tpu_done[i]);
		end
	end

	//////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////
	a_reset_state: assert property (@(posedge clock) disable iff (!rst_n)
		!started |-> !commit && !wait_issue && !acc_nz)
		else begin
			$error("Engine not quiet between reset and the first request");
			bad_reset = 1'b1;
		end

	a_commit_order: assert property (@(posedge clock) disable iff (!rst_n)
		commit |-> commit_no == expect_no && outstanding != '0)
		else begin
			$error("Commit out of sequence or without an accepted request");
			bad_order = 1'b1;
		end

	// A request seen during wait takes no slot
	a_drop: assert property (@(posedge clock) disable iff (!rst_n)
		req && wait_issue |=> !issue)
		else begin
			$error("Request issued while wait_issue was high");
			bad_drop = 1'b1;
		end

	a_no_overflow: assert property (@(posedge clock) disable iff (!rst_n)
		!unit_over)
		else begin
			$error("More instructions sent to a unit than its queue can hold");
			bad_overflow = 1'b1;
		end

	a_latency_hit: assert property (@(posedge clock) disable iff (!rst_n)
		$past(add_start, 4) || $past(mul_start, 6) |-> commit)
		else begin
			$error("Isolated request missed its commit cycle");
			bad_latency = 1'b1;
		end

	a_latency_early: assert property (@(posedge clock) disable iff (!rst_n)
		$past(add_start, 3) || $past(mul_start, 5) |-> !commit)
		else begin
			$error("Isolated request committed early");
			bad_latency = 1'b1;
		end

endmodule

`default_nettype wire

/* tb/tb_blas_engine.sv */
/*
 * Testbench for the BLAS issue engine
 * Directed latency and back-pressure cases, then a random burst
 * checked against an accumulator model
 */

`timescale 1ns/1ns
`default_nettype none

`include "blas_macros.svh"

module tb_blas_engine;

	localparam int N_BURST		= 16;		// Back-to-back MULs to unit 0
	localparam int N_RAND		= 160;
	localparam int N_REQ_MAX	= 200;		// Upper bound over all phases
	localparam int MAX_CYCLES	= N_REQ_MAX * 6 + 800;		// Worst-case spacing plus margin

	logic						clock;
	logic						rst_n;
	logic						req;
	blas_pkg::opcode_t			opcode;
	blas_pkg::data_t			operand;
	blas_pkg::tpu_mask_t		tpu_en;
	wire						wait_issue;
	wire						commit;
	wire blas_pkg::issue_no_t	commit_no;
	wire blas_pkg::data_t		acc [`NUM_TPU-1:0];

	blas_pkg::data_t	model [`NUM_TPU];
	integer				seed			= 32'h96e9d7a7;
	int					accepted_cnt	= 0;
	int					commit_cnt		= 0;
	int					dropped			= 0;
	int					cycles			= 0;

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	blas_engine dut_i (
		.clock		(clock),
		.rst_n		(rst_n),
		.req		(req),
		.opcode		(opcode),
		.operand	(operand),
		.tpu_en		(tpu_en),
		.wait_issue	(wait_issue),
		.commit		(commit),
		.commit_no	(commit_no),
		.acc		(acc)
	);

	bind blas_engine blas_engine_asserts asserts_i (
		.clock		(clock),
		.rst_n		(rst_n),
		.req		(req),
		.opcode		(opcode),
		.tpu_en		(tpu_en),
		.wait_issue	(wait_issue),
		.commit		(commit),
		.commit_no	(commit_no),
		.acc		(acc),
		.issue		(issue),
		.issue_mask	(issue_mask),
		.tpu_done	(tpu_done)
	);

	task automatic stop_on_fail();
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	always @(negedge clock) begin
		if (rst_n && commit)
			commit_cnt <= commit_cnt + 1;
		if (dut_i.asserts_i.any_fail) begin
			$display("Assertion failure in blas_engine_asserts at %0t", $time);
			stop_on_fail();
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout after %0d cycles, %0d of %0d requests committed",
				cycles, commit_cnt, accepted_cnt);
			stop_on_fail();
		end
	end

	//////////////////////////////////////////////////
	// Model and stimulus
	//////////////////////////////////////////////////
	task automatic apply_model(input blas_pkg::opcode_t op, input blas_pkg::data_t val,
			input blas_pkg::tpu_mask_t mask);
		for (int i = 0; i < `NUM_TPU; i++) begin
			if (mask[i]) begin
				case (op)
					blas_pkg::CLR:	model[i] = '0;
					blas_pkg::ADD:	model[i] = model[i] + val;
					default:		model[i] = model[i] * val;		// Truncated to DATA_W
				endcase
			end
		end
	endtask

	// Starts on a rising edge, returns on the next one
	task automatic send_req(input blas_pkg::opcode_t op, input blas_pkg::data_t val,
			input blas_pkg::tpu_mask_t mask);
		req		<= 1'b1;
		opcode	<= op;
		operand	<= val;
		tpu_en	<= mask;
		@(negedge clock);
		if (!wait_issue) begin
			apply_model(op, val, mask);
			accepted_cnt++;
		end else begin
			dropped++;
		end
		@(posedge clock);
	endtask

	task automatic send_random();
		int						r;
		int						r_val;
		int						r_mask;
		blas_pkg::opcode_t		op;
		r		= $random(seed);
		r_val	= $random(seed);
		r_mask	= $random(seed);
		case (r[2:0])
			3'd0:						op = blas_pkg::CLR;
			3'd1, 3'd2, 3'd3, 3'd4:		op = blas_pkg::ADD;
			default:					op = blas_pkg::MUL;
		endcase
		send_req(op, r_val[`DATA_W-1:0], r_mask[`NUM_TPU-1:0]);
	endtask

	task automatic idle(input int n);
		req <= 1'b0;
		repeat (n) @(posedge clock);
	endtask

	task automatic drain_and_check();
		req <= 1'b0;
		while (commit_cnt != accepted_cnt)
			@(posedge clock);
		@(negedge clock);
		for (int i = 0; i < `NUM_TPU; i++) begin
			if (acc[i] !== model[i]) begin
				$display("FAIL %0t acc[%0d] got %h expected %h", $time, i, acc[i], model[i]);
				stop_on_fail();
			end
		end
		@(posedge clock);
	endtask

	initial begin
		int r;
		rst_n	= 1'b0;
		req		= 1'b0;
		opcode	= blas_pkg::CLR;
		operand	= '0;
		tpu_en	= '0;
		for (int i = 0; i < `NUM_TPU; i++)
			model[i] = '0;
		repeat (3) @(posedge clock);
		rst_n <= 1'b1;
		idle(4);

		// Isolated requests on an idle engine
		send_req(blas_pkg::ADD, 16'h0003, 4'b1111);
		drain_and_check();
		idle(2);
		send_req(blas_pkg::MUL, 16'h0005, 4'b0110);
		drain_and_check();

		// Empty masks
		send_req(blas_pkg::ADD, 16'h1234, 4'b0000);
		drain_and_check();
		send_req(blas_pkg::MUL, 16'h0007, 4'b0000);
		drain_and_check();

		// Fill unit 0 until wait_issue holds requests off
		for (int i = 0; i < N_BURST; i++)
			send_req(blas_pkg::MUL, 16'h0003, 4'b0001);
		drain_and_check();
		if (dropped == 0) begin
			$display("MUL burst to unit 0 never raised wait_issue");
			stop_on_fail();
		end

		for (int i = 0; i < N_RAND; i++) begin
			r = $random(seed);
			if (r[1:0] == 2'd0)
				idle(1);
			else
				send_random();
		end
		drain_and_check();
		idle(4);

		if (dut_i.asserts_i.any_fail) begin
			$display("Assertion failure before the end of the run");
			stop_on_fail();
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
